// ==== cpu.sv ====
`timescale 1ns/1ps

module cpu (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] im_addr,
    input  logic [31:0] im_instr,
    output logic        dm_cs,
    output logic        dm_read,
    output logic        dm_write,
    output logic [3:0]  dm_web,
    output logic [31:0] dm_addr,
    output logic [31:0] dm_wdata,
    input  logic [31:0] dm_rdata,
    input  logic        im_stall,
    input  logic        dm_stall
);

    import rv_isa_pkg::*;
    import cpu_pipe_pkg::*;

    localparam if_id_t IF_ID_BUBBLE = '{pc: RESET_PC, instr: NOP_INSTR};

    if_id_t  if_id;
    id_ex_t  id_ex;
    id_ex_t  id_ex_next;
    ex_mem_t ex_mem;
    ex_mem_t ex_mem_next;
    mem_wb_t mem_wb;

    logic            stall;
    logic            redirect;
    logic [XLEN-1:0] target;
    logic            pc_hold;
    logic            if_id_hold;
    logic            if_id_flush;
    logic            id_ex_bubble;
    fwd_sel_t        fwd_rs1;
    fwd_sel_t        fwd_rs2;
    logic [XLEN-1:0] wb_data;

    assign stall = im_stall || dm_stall;

    // Fetch
    program_counter pc_i (
        .clk      (clk),
        .reset    (reset),
        .hold     (stall || pc_hold),
        .redirect (redirect && !stall),
        .target   (target),
        .pc       (im_addr)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            if_id <= IF_ID_BUBBLE;
        end else if (!stall) begin
            if (if_id_flush) begin
                if_id <= IF_ID_BUBBLE;
            end else if (!if_id_hold) begin
                if_id <= '{pc: im_addr, instr: im_instr};
            end
        end
    end

    // Decode
    decode_unit decode_i (
        .instr  (if_id.instr),
        .ctrl   (id_ex_next.ctrl),
        .imm    (id_ex_next.imm),
        .rs1    (id_ex_next.rs1),
        .rs2    (id_ex_next.rs2),
        .rd     (id_ex_next.rd),
        .funct3 (id_ex_next.funct3)
    );

    regfile regfile_i (
        .clk      (clk),
        .reset    (reset),
        .rs1      (id_ex_next.rs1),
        .rs2      (id_ex_next.rs2),
        .rd       (mem_wb.rd),
        .wdata    (wb_data),
        .we       (mem_wb.reg_write && !stall),
        .rs1_data (id_ex_next.rs1_data),
        .rs2_data (id_ex_next.rs2_data)
    );

    assign id_ex_next.pc = if_id.pc;

    hazard_unit hazard_i (
        .id_rs1        (id_ex_next.rs1),
        .id_rs2        (id_ex_next.rs2),
        .ex_rd         (id_ex.rd),
        .ex_mem_read   (id_ex.ctrl.mem_read),
        .ex_rs1        (id_ex.rs1),
        .ex_rs2        (id_ex.rs2),
        .mem_rd        (ex_mem.rd),
        .mem_reg_write (ex_mem.reg_write),
        .wb_rd         (mem_wb.rd),
        .wb_reg_write  (mem_wb.reg_write),
        .redirect      (redirect),
        .pc_hold       (pc_hold),
        .if_id_hold    (if_id_hold),
        .if_id_flush   (if_id_flush),
        .id_ex_bubble  (id_ex_bubble),
        .fwd_rs1       (fwd_rs1),
        .fwd_rs2       (fwd_rs2)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex <= '0;
        end else if (!stall) begin
            id_ex <= id_ex_bubble ? '0 : id_ex_next;
        end
    end

    // Execute
    execute_unit execute_i (
        .id_ex      (id_ex),
        .fwd_rs1    (fwd_rs1),
        .fwd_rs2    (fwd_rs2),
        .mem_result (ex_mem.result),
        .wb_result  (wb_data),
        .ex_mem     (ex_mem_next),
        .redirect   (redirect),
        .target     (target)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem <= '0;
        end else if (!stall) begin
            ex_mem <= ex_mem_next;
        end
    end

    // Memory
    assign dm_cs    = ex_mem.mem_read || ex_mem.mem_write;
    assign dm_read  = ex_mem.mem_read;
    assign dm_write = ex_mem.mem_write;
    assign dm_web   = ex_mem.mem_write ? 4'b0000 : 4'b1111;
    assign dm_addr  = ex_mem.result;
    assign dm_wdata = ex_mem.store_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb <= '0;
        end else if (!stall) begin
            mem_wb.result     <= ex_mem.result;
            mem_wb.load_data  <= dm_rdata;
            mem_wb.rd         <= ex_mem.rd;
            mem_wb.mem_to_reg <= ex_mem.mem_read;
            mem_wb.reg_write  <= ex_mem.reg_write;
        end
    end

    // Writeback
    assign wb_data = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.result;

endmodule

// ==== cpu_pipe_pkg.sv ====
package cpu_pipe_pkg;

    import rv_isa_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_COPY_B
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_type_t;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src_imm;
        logic    alu_src_pc;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    branch;
        logic    jump;
        logic    jump_reg;
        logic    link;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        logic [2:0]            funct3;
        ctrl_t                 ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       load_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  mem_to_reg;
        logic                  reg_write;
    } mem_wb_t;

endpackage

// ==== decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
    input  logic [31:0]                 instr,
    output cpu_pipe_pkg::ctrl_t         ctrl,
    output logic [rv_isa_pkg::XLEN-1:0] imm,
    output logic [4:0]                  rs1,
    output logic [4:0]                  rs2,
    output logic [4:0]                  rd,
    output logic [2:0]                  funct3
);

    import rv_isa_pkg::*;
    import cpu_pipe_pkg::*;

    opcode_t   opcode;
    imm_type_t imm_type;
    logic      alt_op;

    function automatic alu_op_t alu_func(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SR:      return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign opcode = opcode_t'(instr[OPCODE_W-1:0]);
    assign rd     = instr[RD_LSB +: REG_ADDR_W];
    assign rs1    = instr[RS1_LSB +: REG_ADDR_W];
    assign rs2    = instr[RS2_LSB +: REG_ADDR_W];
    assign funct3 = instr[FUNCT3_LSB +: 3];
    assign alt_op = instr[ALT_OP_BIT];

    always_comb begin
        ctrl     = '0;
        ctrl.alu_op = ALU_ADD;
        imm_type = IMM_I;
        case (opcode)
            OP_LUI: begin
                ctrl.alu_op      = ALU_COPY_B;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                imm_type         = IMM_U;
            end
            OP_AUIPC: begin
                ctrl.alu_src_pc  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                imm_type         = IMM_U;
            end
            OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
                imm_type       = IMM_J;
            end
            OP_JALR: begin
                ctrl.jump      = 1'b1;
                ctrl.jump_reg  = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_BRANCH: begin
                ctrl.branch = 1'b1;
                imm_type    = IMM_B;
            end
            OP_LOAD: begin
                if (funct3 == F3_WORD) begin
                    ctrl.mem_read    = 1'b1;
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                end
            end
            OP_STORE: begin
                if (funct3 == F3_WORD) begin
                    ctrl.mem_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                end
                imm_type = IMM_S;
            end
            OP_IMM: begin
                // Bit 30 is immediate data except for SRAI
                ctrl.alu_op      = alu_func(funct3, alt_op && (funct3 == F3_SR));
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            OP_REG: begin
                ctrl.alu_op    = alu_func(funct3, alt_op);
                ctrl.reg_write = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    always_comb begin
        case (imm_type)
            IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            IMM_U:   imm = {instr[31:12], 12'b0};
            IMM_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

// ==== execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  cpu_pipe_pkg::id_ex_t        id_ex,
    input  cpu_pipe_pkg::fwd_sel_t      fwd_rs1,
    input  cpu_pipe_pkg::fwd_sel_t      fwd_rs2,
    input  logic [rv_isa_pkg::XLEN-1:0] mem_result,
    input  logic [rv_isa_pkg::XLEN-1:0] wb_result,
    output cpu_pipe_pkg::ex_mem_t       ex_mem,
    output logic                        redirect,
    output logic [rv_isa_pkg::XLEN-1:0] target
);

    import rv_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] jalr_sum;
    logic [4:0]      shamt;
    logic            taken;

    always_comb begin
        case (fwd_rs1)
            FWD_MEM: rs1_val = mem_result;
            FWD_WB:  rs1_val = wb_result;
            default: rs1_val = id_ex.rs1_data;
        endcase
        case (fwd_rs2)
            FWD_MEM: rs2_val = mem_result;
            FWD_WB:  rs2_val = wb_result;
            default: rs2_val = id_ex.rs2_data;
        endcase
    end

    assign op_a  = id_ex.ctrl.alu_src_pc ? id_ex.pc : rs1_val;
    assign op_b  = id_ex.ctrl.alu_src_imm ? id_ex.imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_COPY_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // Branch compare on forwarded operands
    always_comb begin
        case (id_ex.funct3)
            F3_BEQ:  taken = (rs1_val == rs2_val);
            F3_BNE:  taken = (rs1_val != rs2_val);
            F3_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
            F3_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            default: taken = 1'b0;
        endcase
    end

    assign redirect = id_ex.ctrl.jump || (id_ex.ctrl.branch && taken);
    assign jalr_sum = rs1_val + id_ex.imm;
    assign target   = id_ex.ctrl.jump_reg ? {jalr_sum[XLEN-1:1], 1'b0}
                                          : id_ex.pc + id_ex.imm;

    always_comb begin
        ex_mem.result     = id_ex.ctrl.link ? id_ex.pc + 32'd4 : alu_res;
        ex_mem.store_data = rs2_val;
        ex_mem.rd         = id_ex.rd;
        ex_mem.mem_read   = id_ex.ctrl.mem_read;
        ex_mem.mem_write  = id_ex.ctrl.mem_write;
        ex_mem.reg_write  = id_ex.ctrl.reg_write;
    end

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  logic [4:0]             id_rs1,
    input  logic [4:0]             id_rs2,
    input  logic [4:0]             ex_rd,
    input  logic                   ex_mem_read,
    input  logic [4:0]             ex_rs1,
    input  logic [4:0]             ex_rs2,
    input  logic [4:0]             mem_rd,
    input  logic                   mem_reg_write,
    input  logic [4:0]             wb_rd,
    input  logic                   wb_reg_write,
    input  logic                   redirect,
    output logic                   pc_hold,
    output logic                   if_id_hold,
    output logic                   if_id_flush,
    output logic                   id_ex_bubble,
    output cpu_pipe_pkg::fwd_sel_t fwd_rs1,
    output cpu_pipe_pkg::fwd_sel_t fwd_rs2
);

    import cpu_pipe_pkg::*;

    logic load_use;

    // Memory stage holds the younger result, so it wins over writeback
    function automatic fwd_sel_t pick_source(input logic [4:0] src);
        if (src == 5'd0) begin
            return FWD_NONE;
        end else if (mem_reg_write && mem_rd == src) begin
            return FWD_MEM;
        end else if (wb_reg_write && wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    // Load data only exists after the memory stage
    assign load_use = ex_mem_read && (ex_rd != 5'd0) &&
                      ((ex_rd == id_rs1) || (ex_rd == id_rs2));

    assign pc_hold      = load_use;
    assign if_id_hold   = load_use;
    assign if_id_flush  = redirect;
    assign id_ex_bubble = load_use || redirect;

    assign fwd_rs1 = pick_source(ex_rs1);
    assign fwd_rs2 = pick_source(ex_rs2);

endmodule

// ==== program_counter.sv ====
`timescale 1ns/1ps

module program_counter (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        hold,
    input  logic                        redirect,
    input  logic [rv_isa_pkg::XLEN-1:0] target,
    output logic [rv_isa_pkg::XLEN-1:0] pc
);

    import rv_isa_pkg::*;
    import cpu_pipe_pkg::*;

    logic [XLEN-1:0] pc_plus4;

    assign pc_plus4 = pc + 32'd4;

    // Redirect beats hold so a taken branch survives an interlock
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= target;
        end else if (!hold) begin
            pc <= pc_plus4;
        end
    end

endmodule

// ==== project.f ====
+incdir+.
rv_isa_pkg.sv
cpu_pipe_pkg.sv
program_counter.sv
regfile.sv
decode_unit.sv
hazard_unit.sv
execute_unit.sv
cpu.sv
tb_cpu.sv

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [4:0]                  rs1,
    input  logic [4:0]                  rs2,
    input  logic [4:0]                  rd,
    input  logic [rv_isa_pkg::XLEN-1:0] wdata,
    input  logic                        we,
    output logic [rv_isa_pkg::XLEN-1:0] rs1_data,
    output logic [rv_isa_pkg::XLEN-1:0] rs2_data
);

    import rv_isa_pkg::*;

    logic [XLEN-1:0] regs [1:31];
    logic            wr_active;

    assign wr_active = we && (rd != 5'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_active) begin
            regs[rd] <= wdata;
        end
    end

    // Same-cycle write is seen by the reader
    assign rs1_data = (rs1 == 5'd0) ? '0 : (wr_active && rs1 == rd) ? wdata : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : (wr_active && rs2 == rd) ? wdata : regs[rs2];

endmodule

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Instruction field positions
    localparam int OPCODE_W    = 7;
    localparam int RD_LSB      = 7;
    localparam int FUNCT3_LSB  = 12;
    localparam int RS1_LSB     = 15;
    localparam int RS2_LSB     = 20;
    localparam int ALT_OP_BIT  = 30;

    typedef enum logic [OPCODE_W-1:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    // ALU funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // Only word accesses are decoded
    localparam logic [2:0] F3_WORD = 3'b010;

    // ADDI x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

// ==== tb_cpu_programs.svh ====
// Each program ends in a jump to itself, so no store follows the last expected one
task automatic fill_program_table();
    // Dependent ALU chain, each result feeds the next one or two instructions
    start_program("alu_chain");
    add_instr(i_type(OP_IMM, F3_ADD_SUB, 1, 0, 5));
    add_instr(i_type(OP_IMM, F3_ADD_SUB, 2, 1, 7));
    add_instr(r_type(F3_ADD_SUB, 'h00, 3, 1, 2));
    add_instr(r_type(F3_ADD_SUB, 'h20, 4, 3, 1));
    add_instr(s_type(4, 0, 'h100));
    add_instr(i_type(OP_IMM, F3_SLL, 5, 4, 3));
    add_instr(i_type(OP_IMM, F3_SR, 6, 5, 2));
    add_instr(i_type(OP_IMM, F3_XOR, 7, 6, -1));
    add_instr(i_type(OP_IMM, F3_SR, 8, 7, 'h401));
    add_instr(s_type(8, 0, 'h104));
    add_instr(r_type(F3_SLT, 'h00, 9, 8, 6));
    add_instr(r_type(F3_SLTU, 'h00, 10, 8, 6));
    add_instr(r_type(F3_SLL, 'h00, 11, 9, 6));
    add_instr(r_type(F3_OR, 'h00, 12, 11, 10));
    add_instr(s_type(12, 0, 'h108));
    add_instr(u_type(OP_LUI, 13, 'h12345));
    // AUIPC sits at pc 0x40
    add_instr(u_type(OP_AUIPC, 14, 1));
    add_instr(r_type(F3_AND, 'h00, 15, 13, 14));
    add_instr(r_type(F3_SR, 'h00, 16, 13, 9));
    add_instr(s_type(13, 0, 'h10c));
    add_instr(s_type(14, 0, 'h110));
    add_instr(s_type(15, 0, 'h114));
    add_instr(s_type(16, 0, 'h118));
    add_instr(j_type(0, 0));
    add_store('h100, 32'h0000_000c);
    add_store('h104, 32'hffff_fff3);
    add_store('h108, 32'h0100_0000);
    add_store('h10c, 32'h1234_5000);
    add_store('h110, 32'h0000_1040);
    add_store('h114, 32'h0000_1000);
    add_store('h118, 32'h091a_2800);

    // Loads used by the very next instruction
    start_program("load_use");
    add_data('h80, 32'h0000_0123);
    add_data('h84, 32'h7fff_fff0);
    add_instr(i_type(OP_LOAD, F3_WORD, 1, 0, 'h80));
    add_instr(i_type(OP_IMM, F3_ADD_SUB, 2, 1, 'h10));
    add_instr(s_type(2, 0, 'h100));
    add_instr(i_type(OP_LOAD, F3_WORD, 3, 0, 'h84));
    add_instr(r_type(F3_ADD_SUB, 'h00, 4, 3, 2));
    add_instr(s_type(4, 0, 'h104));
    add_instr(i_type(OP_LOAD, F3_WORD, 5, 0, 'h84));
    add_instr(s_type(5, 0, 'h108));
    add_instr(i_type(OP_LOAD, F3_WORD, 6, 0, 'h100));
    add_instr(r_type(F3_ADD_SUB, 'h20, 7, 6, 1));
    add_instr(s_type(7, 0, 'h10c));
    add_instr(j_type(0, 0));
    add_store('h100, 32'h0000_0133);
    add_store('h104, 32'h8000_0123);
    add_store('h108, 32'h7fff_fff0);
    add_store('h10c, 32'h0000_0010);

    // x1 = 5, x2 = -3, x3 = 5; stores to 0x18x sit on skipped paths
    start_program("branches");
    add_instr(i_type(OP_IMM, F3_ADD_SUB, 1, 0, 5));
    add_instr(i_type(OP_IMM, F3_ADD_SUB, 2, 0, -3));
    add_instr(i_type(OP_IMM, F3_ADD_SUB, 3, 0, 5));
    add_instr(b_type(F3_BEQ, 1, 3, 12));
    add_instr(s_type(1, 0, 'h180));
    add_instr(s_type(1, 0, 'h184));
    add_instr(b_type(F3_BEQ, 1, 2, 12));
    add_instr(s_type(1, 0, 'h100));
    add_instr(b_type(F3_BNE, 1, 2, 12));
    add_instr(s_type(2, 0, 'h188));
    add_instr(s_type(2, 0, 'h18c));
    add_instr(b_type(F3_BLT, 2, 1, 12));
    add_instr(s_type(3, 0, 'h190));
    add_instr(s_type(3, 0, 'h194));
    add_instr(b_type(F3_BLT, 1, 2, 12));
    add_instr(s_type(2, 0, 'h104));
    add_instr(b_type(F3_BGE, 1, 3, 12));
    add_instr(s_type(1, 0, 'h198));
    add_instr(s_type(1, 0, 'h19c));
    add_instr(b_type(F3_BGE, 2, 1, 12));
    add_instr(b_type(F3_BNE, 1, 3, 12));
    add_instr(s_type(3, 0, 'h108));
    add_instr(s_type(2, 0, 'h10c));
    add_instr(j_type(0, 0));
    add_store('h100, 32'h0000_0005);
    add_store('h104, 32'hffff_fffd);
    add_store('h108, 32'h0000_0005);
    add_store('h10c, 32'hffff_fffd);

    // JALR targets 41 and 57 land on 40 and 56
    start_program("jumps");
    add_instr(j_type(1, 12));
    add_instr(s_type(0, 0, 'h180));
    add_instr(s_type(0, 0, 'h184));
    add_instr(s_type(1, 0, 'h100));
    add_instr(i_type(OP_IMM, F3_ADD_SUB, 5, 0, 41));
    add_instr(i_type(OP_JALR, 0, 6, 5, 0));
    add_instr(s_type(0, 0, 'h188));
    add_instr(s_type(0, 0, 'h18c));
    add_instr(s_type(0, 0, 'h190));
    add_instr(s_type(0, 0, 'h194));
    add_instr(s_type(6, 0, 'h104));
    add_instr(i_type(OP_JALR, 0, 7, 6, 33));
    add_instr(s_type(0, 0, 'h198));
    add_instr(s_type(0, 0, 'h19c));
    add_instr(s_type(7, 0, 'h108));
    add_instr(j_type(0, 0));
    add_store('h100, 32'h0000_0004);
    add_store('h104, 32'h0000_0018);
    add_store('h108, 32'h0000_0030);

    for (int i = 0; i < 4; i++) begin
        repeat_with_stalls(i);
    end
endtask

// ==== tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

    import rv_isa_pkg::*;

    localparam int MAX_ENTRIES  = 8;
    localparam int MAX_INSTR    = 24;
    localparam int MAX_STORES   = 8;
    localparam int MAX_DATA     = 4;
    localparam int MEM_WORDS    = 256;
    localparam int DRAIN_CYCLES = 16;

    logic        clk;
    logic        reset;
    logic [31:0] im_addr;
    logic [31:0] im_instr;
    logic        dm_cs;
    logic        dm_read;
    logic        dm_write;
    logic [3:0]  dm_web;
    logic [31:0] dm_addr;
    logic [31:0] dm_wdata;
    logic [31:0] dm_rdata;
    logic        im_stall;
    logic        dm_stall;

    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];

    string       prog_name   [MAX_ENTRIES];
    logic [31:0] prog_code   [MAX_ENTRIES][MAX_INSTR];
    int          prog_len    [MAX_ENTRIES];
    logic [31:0] data_addr   [MAX_ENTRIES][MAX_DATA];
    logic [31:0] data_value  [MAX_ENTRIES][MAX_DATA];
    int          data_count  [MAX_ENTRIES];
    logic [31:0] store_addr  [MAX_ENTRIES][MAX_STORES];
    logic [31:0] store_data  [MAX_ENTRIES][MAX_STORES];
    int          store_count [MAX_ENTRIES];
    bit          prog_stall  [MAX_ENTRIES];
    int          num_entries;

    logic [31:0] lfsr_state;
    bit          stall_enable;
    int          watchdog_cycles;
    int          value_errors;
    int          other_errors;

    cpu cpu_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Both memories are combinational on read
    assign im_instr = imem[im_addr[9:2]];
    // Read data is only valid while a load is selected
    assign dm_rdata = (dm_cs && dm_read) ? dmem[dm_addr[9:2]] : 32'hx;

    always @(posedge clk) begin
        if (dm_cs && dm_write) begin
            dmem[dm_addr[9:2]] <= dm_wdata;
        end
    end

    function automatic logic [31:0] r_type(input int f3, input int f7, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], F3_WORD, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                           input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] op, input int rd, input int imm);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_random_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
    endtask

    task automatic start_program(input string name);
        prog_name[num_entries] = name;
        prog_len[num_entries] = 0;
        data_count[num_entries] = 0;
        store_count[num_entries] = 0;
        prog_stall[num_entries] = 1'b0;
        num_entries++;
    endtask

    task automatic add_instr(input logic [31:0] word);
        int p;
        p = num_entries - 1;
        prog_code[p][prog_len[p]] = word;
        prog_len[p]++;
    endtask

    task automatic add_data(input logic [31:0] addr, input logic [31:0] value);
        int p;
        p = num_entries - 1;
        data_addr[p][data_count[p]] = addr;
        data_value[p][data_count[p]] = value;
        data_count[p]++;
    endtask

    task automatic add_store(input logic [31:0] addr, input logic [31:0] value);
        int p;
        p = num_entries - 1;
        store_addr[p][store_count[p]] = addr;
        store_data[p][store_count[p]] = value;
        store_count[p]++;
    endtask

    task automatic repeat_with_stalls(input int src);
        int dst;
        dst = num_entries;
        start_program({prog_name[src], "_stall"});
        prog_stall[dst] = 1'b1;
        for (int i = 0; i < prog_len[src]; i++) begin
            add_instr(prog_code[src][i]);
        end
        for (int i = 0; i < data_count[src]; i++) begin
            add_data(data_addr[src][i], data_value[src][i]);
        end
        for (int i = 0; i < store_count[src]; i++) begin
            add_store(store_addr[src][i], store_data[src][i]);
        end
    endtask

    `include "tb_cpu_programs.svh"

    task automatic load_memories(input int p);
        logic [7:0] idx;
        for (int i = 0; i < MEM_WORDS; i++) begin
            idx = i[7:0];
            // ADDI x0 carrying the word index, still a no-op
            imem[i] = i_type(OP_IMM, F3_ADD_SUB, 0, 0, i);
            dmem[i] = {~idx, idx, ~idx, idx};
        end
        for (int i = 0; i < prog_len[p]; i++) begin
            imem[i] = prog_code[p][i];
        end
        for (int i = 0; i < data_count[p]; i++) begin
            dmem[data_addr[p][i][9:2]] = data_value[p][i];
        end
    endtask

    // Memories load after the first reset edge so a store in flight cannot land on them
    task automatic reset_and_load(input int p);
        @(posedge clk);
        #5;
        reset = 1'b1;
        stall_enable = 1'b0;
        @(posedge clk);
        #5;
        load_memories(p);
        repeat (7) @(posedge clk);
        #5;
        reset = 1'b0;
        stall_enable = prog_stall[p];
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        value_errors++;
    endtask

    task automatic check_reset_state();
        reset_and_load(0);
        @(negedge clk);
        if (im_addr !== 32'h0) begin
            report_mismatch("reset im_addr", 32'h0, im_addr);
        end
        if (dm_cs !== 1'b0) begin
            report_mismatch("reset dm_cs", 32'h0, {31'h0, dm_cs});
        end
        if (dm_read !== 1'b0) begin
            report_mismatch("reset dm_read", 32'h0, {31'h0, dm_read});
        end
        if (dm_write !== 1'b0) begin
            report_mismatch("reset dm_write", 32'h0, {31'h0, dm_write});
        end
        if (dm_web !== 4'b1111) begin
            report_mismatch("reset dm_web", 32'hf, {28'h0, dm_web});
        end
        @(negedge clk);
        if (im_addr !== 32'h4) begin
            report_mismatch("first fetch im_addr", 32'h4, im_addr);
        end
    endtask

    // A store counts once, on the edge where the pipeline is not frozen
    task automatic watch_one_cycle(input int p, inout int seen);
        @(negedge clk);
        if (dm_cs === 1'b1 && dm_write === 1'b1 && !im_stall && !dm_stall) begin
            if (dm_web !== 4'b0000) begin
                report_mismatch({prog_name[p], " dm_web"}, 32'h0, {28'h0, dm_web});
            end
            if (seen >= store_count[p]) begin
                $display("ERROR: %s made an extra store of %h to %h", prog_name[p],
                         dm_wdata, dm_addr);
                other_errors++;
            end else if (dm_addr !== store_addr[p][seen] ||
                         dm_wdata !== store_data[p][seen]) begin
                $display("FAIL %s store %0d: expected %h at %h, actual %h at %h",
                         prog_name[p], seen, store_data[p][seen], store_addr[p][seen],
                         dm_wdata, dm_addr);
                value_errors++;
            end
            seen++;
        end
    endtask

    task automatic run_program(input int p);
        int seen;
        int cycles;
        int limit;
        reset_and_load(p);
        seen = 0;
        cycles = 0;
        limit = prog_len[p] * 8 * (prog_stall[p] ? 2 : 1);
        while (seen < store_count[p] && cycles < limit) begin
            watch_one_cycle(p, seen);
            cycles++;
        end
        if (seen < store_count[p]) begin
            $display("ERROR: %s made only %0d of %0d stores within %0d cycles",
                     prog_name[p], seen, store_count[p], limit);
            other_errors++;
        end
        repeat (DRAIN_CYCLES) begin
            watch_one_cycle(p, seen);
        end
    endtask

    initial begin
        logic use_lfsr;
        logic a;
        logic b;
        im_stall = 1'b0;
        dm_stall = 1'b0;
        forever begin
            @(posedge clk);
            use_lfsr = stall_enable;
            #5;
            if (use_lfsr) begin
                take_random_bit(a);
                take_random_bit(b);
                im_stall = a & b;
                take_random_bit(a);
                take_random_bit(b);
                dm_stall = a & b;
            end else begin
                im_stall = 1'b0;
                dm_stall = 1'b0;
            end
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles", watchdog_cycles);
        $display("errors: %0d wrong values, %0d other failures", value_errors,
                 other_errors + 1);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        stall_enable = 1'b0;
        lfsr_state = 32'h980a5bea;
        value_errors = 0;
        other_errors = 0;
        num_entries = 0;
        watchdog_cycles = 0;
        fill_program_table();
        load_memories(0);
        for (int p = 0; p < num_entries; p++) begin
            watchdog_cycles += (prog_len[p] * 8 + 40) * (prog_stall[p] ? 2 : 1);
        end
        check_reset_state();
        for (int p = 0; p < num_entries; p++) begin
            run_program(p);
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
